//--- tb.f
src/nnNumericPkg.sv
src/nnLayerPkg.sv
src/inputLatch.sv
src/neuronNode.sv
src/resultCollector.sv
src/neuralLayerTop.sv
sim/tbNeuralLayer.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f \
	--top-module tbNeuralLayer \
	--Mdir obj_dir \
	-o simv

./obj_dir/simv 2>&1 | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
	exit 0
else
	exit 1
fi

//--- sim/layer_trace.txt
# Columns: input act[0] to act[9], then expected output act[0] to act[3].
# All values are signed 8-bit numbers in two's complement hex.
00 00 00 00 00 00 00 00 00 00 00 02 08 00
01 00 00 00 00 00 00 00 00 00 00 02 08 00
00 00 00 0a 00 00 00 00 00 00 01 03 10 00
00 64 00 00 00 00 00 00 00 00 00 47 43 00
00 00 00 00 7f 00 00 00 00 00 00 2c 6f 1c
00 00 00 00 80 00 00 00 00 00 0a 00 00 00
00 00 00 7f 7f 00 00 00 00 00 30 3c 7f 00
00 00 00 00 00 00 00 00 7f 00 0e 00 08 4f
00 00 00 00 00 80 00 00 00 00 00 3e 5c 00
00 64 00 00 00 80 00 00 00 00 00 7f 7f 00
00 00 00 04 00 00 00 00 00 00 00 02 0b 00
00 00 00 03 00 00 00 00 00 03 00 03 0b 00
00 7f 00 00 75 00 00 00 00 00 00 7f 7f 1a
ff 00 00 00 00 00 00 00 00 00 00 02 08 00
0a f6 00 00 00 00 00 00 00 00 01 00 02 04
00 00 00 00 00 00 00 ce 00 00 1c 00 08 00
00 00 00 00 00 00 00 32 32 00 00 00 08 30
00 00 00 00 00 00 14 00 00 00 00 07 05 00
00 00 00 00 00 00 00 00 00 e2 00 01 03 03
00 00 40 00 00 00 00 00 00 00 01 00 26 00
32 00 00 00 00 32 00 00 00 00 13 00 00 31

//--- sim/tbNeuralLayer.sv
`timescale 1ns/1ps

module tbNeuralLayer;
	import nnNumericPkg::*;
	import nnLayerPkg::*;

	localparam int WAIT_LIMIT = 200;
	localparam int LONG_STALL = 40;

	logic clk;
	logic reset;
	logic inReq;
	logic inAck;
	inVector_t inData;
	logic outReq;
	logic outAck;
	outVector_t outData;

	inVector_t stimQ [$];
	outVector_t expectQ [$];

	int valueErrors;
	int protocolErrors;
	int timeoutErrors;
	int setupErrors;
	int accepted;
	int popped;
	int maxOutstanding;
	bit timedOut;
	logic prevInAck;
	logic prevOutReq;
	logic prevInReq;
	logic prevOutAck;

	neuralLayerTop dut_i
	(
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inAck(inAck),
		.inData(inData),
		.outReq(outReq),
		.outAck(outAck),
		.outData(outData)
	);

	always #2 clk = ~clk;

	// Each trace line holds act[0]..act[9] of a vector, then the expected act[0]..act[3].
	task automatic loadTrace();
		int fd;
		int n;
		string line;
		logic [7:0] b [14];
		inVector_t v;
		outVector_t e;
		fd = $fopen("sim/layer_trace.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the trace file sim/layer_trace.txt");
			setupErrors++;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line[0] != 8'h23)
			begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7], b[8], b[9],
					b[10], b[11], b[12], b[13]);
				if (n == 14)
				begin
					for (int i = 0; i < NUM_INPUTS; i++)
						v.act[i] = b[i];
					for (int i = 0; i < NUM_NEURONS; i++)
						e.act[i] = b[NUM_INPUTS+i];
					stimQ.push_back(v);
					expectQ.push_back(e);
				end
				else
				begin
					$display("A trace line could not be read: %s", line);
					setupErrors++;
				end
			end
		end
		$fclose(fd);
		if (stimQ.size() == 0)
		begin
			$display("The trace holds no vectors");
			setupErrors++;
		end
	endtask

	task automatic checkIdleOutputs(input string when);
		if (inAck !== 1'b0 || outReq !== 1'b0)
		begin
			$display("CHECK FAILED inAck/outReq %s: inAck=0x%h outReq=0x%h, expected 0x0",
				when, inAck, outReq);
			protocolErrors++;
		end
	endtask

	task automatic waitInAck(input logic level, output bit ok);
		int cycles;
		cycles = 0;
		while (inAck !== level && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		ok = (inAck === level);
		if (!ok)
		begin
			$display("Timeout: inAck did not go to %0b within %0d cycles", level, WAIT_LIMIT);
			timeoutErrors++;
			timedOut = 1'b1;
		end
	endtask

	task automatic waitOutReq(input logic level, output bit ok);
		int cycles;
		cycles = 0;
		while (outReq !== level && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		ok = (outReq === level);
		if (!ok)
		begin
			$display("Timeout: outReq did not go to %0b within %0d cycles", level, WAIT_LIMIT);
			timeoutErrors++;
			timedOut = 1'b1;
		end
	endtask

	task automatic sendAll();
		bit ok;
		for (int idx = 0; idx < stimQ.size(); idx++)
		begin
			repeat ($urandom_range(3, 0)) @(negedge clk);
			inData = stimQ[idx];
			inReq = 1'b1;
			waitInAck(1'b1, ok);
			if (!ok)
				return;
			inReq = 1'b0;
			waitInAck(1'b0, ok);
			if (!ok)
				return;
		end
	endtask

	task automatic compareResult(input int idx);
		for (int n = 0; n < NUM_NEURONS; n++)
		begin
			if (outData.act[n] !== expectQ[idx].act[n])
			begin
				$display("CHECK FAILED outData.act[%0d] for vector %0d: expected 0x%h, got 0x%h",
					n, idx, expectQ[idx].act[n], outData.act[n]);
				valueErrors++;
			end
		end
	endtask

	task automatic receiveAll();
		bit ok;
		int delay;
		for (int idx = 0; idx < expectQ.size(); idx++)
		begin
			waitOutReq(1'b1, ok);
			if (!ok)
				return;
			// Two long stalls let the credits run out so that inAck has to hold off.
			if (idx == 5 || idx == 13)
				delay = LONG_STALL;
			else
				delay = $urandom_range(12, 0);
			repeat (delay) @(negedge clk);
			compareResult(idx);
			outAck = 1'b1;
			waitOutReq(1'b0, ok);
			if (!ok)
				return;
			outAck = 1'b0;
		end
		repeat (20)
		begin
			@(negedge clk);
			if (outReq === 1'b1)
			begin
				$display("An extra result appeared after all expected results");
				valueErrors++;
				return;
			end
		end
	endtask

	// Outputs sampled here changed at the previous rising edge.
	// They are judged against the inputs that the DUT saw at that edge.
	always @(posedge clk)
	begin
		if (reset)
		begin
			prevInAck = 1'b0;
			prevOutReq = 1'b0;
			prevInReq = 1'b0;
			prevOutAck = 1'b0;
		end
		else
		begin
			if (prevInAck && !inAck && prevInReq)
			begin
				$display("inAck fell while inReq was still high");
				protocolErrors++;
			end
			if (!prevOutReq && outReq && prevOutAck)
			begin
				$display("outReq rose while outAck was still high");
				protocolErrors++;
			end
			if (!prevInAck && inAck)
				accepted++;
			if (prevOutReq && !outReq)
				popped++;
			if (accepted - popped > QUEUE_DEPTH)
			begin
				$display("More vectors were accepted than the queue has slots");
				protocolErrors++;
			end
			if (accepted - popped > maxOutstanding)
				maxOutstanding = accepted - popped;
			prevInAck = inAck;
			prevOutReq = outReq;
			prevInReq = inReq;
			prevOutAck = outAck;
		end
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		inReq = 1'b0;
		inData = '0;
		outAck = 1'b0;
		valueErrors = 0;
		protocolErrors = 0;
		timeoutErrors = 0;
		setupErrors = 0;
		accepted = 0;
		popped = 0;
		maxOutstanding = 0;
		timedOut = 1'b0;
		void'($urandom(86426));
		loadTrace();
		repeat (8)
		begin
			@(negedge clk);
			checkIdleOutputs("during reset");
		end
		reset = 1'b0;
		@(negedge clk);
		checkIdleOutputs("in the first cycle after reset");
		if (setupErrors == 0)
		begin
			fork
				sendAll();
				receiveAll();
			join
		end
		if (setupErrors == 0 && !timedOut && maxOutstanding != QUEUE_DEPTH)
		begin
			$display("The receiver stalls never filled all %0d credits", QUEUE_DEPTH);
			protocolErrors++;
		end
		$display("Errors: value %0d, protocol %0d, timeout %0d, setup %0d",
			valueErrors, protocolErrors, timeoutErrors, setupErrors);
		if (valueErrors + protocolErrors + timeoutErrors + setupErrors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- src/neuralLayerTop.sv
`timescale 1ns/1ps

module neuralLayerTop
(
	input  logic clk,
	input  logic reset,
	input  logic inReq,
	output logic inAck,
	input  nnLayerPkg::inVector_t inData,
	output logic outReq,
	input  logic outAck,
	output nnLayerPkg::outVector_t outData
);
	import nnLayerPkg::*;

	inVector_t vectorData;
	outVector_t nodeActivation;
	logic [NUM_NEURONS-1:0] nodeValid;
	logic start;
	logic slotFreed;

	inputLatch latch_i
	(
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inAck(inAck),
		.inData(inData),
		.slotFreed(slotFreed),
		.start(start),
		.vectorData(vectorData)
	);

	// Every node sees the same broadcast vector and keeps its own weight row.
	for (genvar n = 0; n < NUM_NEURONS; n++)
	begin : gNode
		neuronNode #(.neuronIndex(n)) node_i
		(
			.clk(clk),
			.reset(reset),
			.start(start),
			.vectorData(vectorData),
			.activation(nodeActivation.act[n]),
			.nodeValid(nodeValid[n])
		);
	end

	resultCollector collector_i
	(
		.clk(clk),
		.reset(reset),
		.nodeActivation(nodeActivation),
		.nodeValid(nodeValid),
		.slotFreed(slotFreed),
		.outReq(outReq),
		.outAck(outAck),
		.outData(outData)
	);

endmodule

//--- src/resultCollector.sv
`timescale 1ns/1ps

module resultCollector
(
	input  logic clk,
	input  logic reset,
	input  nnLayerPkg::outVector_t nodeActivation,
	input  logic [nnLayerPkg::NUM_NEURONS-1:0] nodeValid,
	output logic slotFreed,
	output logic outReq,
	input  logic outAck,
	output nnLayerPkg::outVector_t outData
);
	import nnLayerPkg::*;

	typedef enum logic [1:0] {idle, requesting, waitAckLow} collectState_t;

	collectState_t state;
	outVector_t queue [QUEUE_DEPTH];
	queuePtr_t wrPtr;
	queuePtr_t rdPtr;
	count_t count;
	logic wrEn;
	logic pop;

	assign wrEn = &nodeValid;
	assign pop = (state == requesting) && outAck;
	assign outData = queue[rdPtr];

	always_ff @(posedge clk)
	begin
		if (wrEn)
			queue[wrPtr] <= nodeActivation;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			slotFreed <= 1'b0;
		end
		else
		begin
			slotFreed <= pop;
			if (wrEn)
				wrPtr <= wrPtr + queuePtr_t'(1);
			if (pop)
				rdPtr <= rdPtr + queuePtr_t'(1);
			case ({wrEn, pop})
				2'b10: count <= count + count_t'(1);
				2'b01: count <= count - count_t'(1);
				default: count <= count;
			endcase
		end
	end

	// The head stays on outData until the receiver has taken it and let go of outAck.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			outReq <= 1'b0;
		end
		else
		begin
			case (state)
				idle:
				begin
					if (count != '0)
					begin
						outReq <= 1'b1;
						state <= requesting;
					end
				end
				requesting:
				begin
					if (outAck)
					begin
						outReq <= 1'b0;
						state <= waitAckLow;
					end
				end
				waitAckLow:
				begin
					if (!outAck)
						state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	nodesInStep: assert property (@(posedge clk) disable iff (reset)
		(nodeValid == '0) || (&nodeValid));

	// Credits in the input latch must keep the queue from overflowing.
	noOverflow: assert property (@(posedge clk) disable iff (reset)
		wrEn |-> (count != count_t'(QUEUE_DEPTH)));

endmodule

//--- src/neuronNode.sv
`timescale 1ns/1ps

module neuronNode
#(
	parameter int neuronIndex = 0
)
(
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  nnLayerPkg::inVector_t vectorData,
	output nnNumericPkg::activation_t activation,
	output logic nodeValid
);
	import nnNumericPkg::*;
	import nnLayerPkg::*;

	activation_t actReg [NUM_INPUTS];
	product_t products [NUM_INPUTS];
	accum_t sum;
	accum_t accReg;
	logic inValid;
	logic sumValid;
	logic roundUp;
	logic [ACT_W:0] rounded;
	activation_t actNext;

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			for (int i = 0; i < NUM_INPUTS; i++)
			begin
				actReg[i] <= vectorData.act[i];
			end
		end
	end

	always_comb
	begin
		for (int i = 0; i < NUM_INPUTS; i++)
		begin
			products[i] = actReg[i] * WEIGHTS[neuronIndex][i];
		end
	end

	always_comb
	begin
		sum = accum_t'(BIASES[neuronIndex]);
		for (int i = 0; i < NUM_INPUTS; i++)
		begin
			sum = sum + accum_t'(products[i]);
		end
	end

	always_ff @(posedge clk)
	begin
		accReg <= sum;
	end

	// Rectify, then saturate anything at or above 2.0, then round to nearest.
	always_comb
	begin
		roundUp = accReg[FRAC_SHIFT-1] && (accReg[FRAC_SHIFT-2:0] != '0);
		rounded = {1'b0, accReg[FRAC_SHIFT+ACT_W-1:FRAC_SHIFT]} + {{ACT_W{1'b0}}, roundUp};
		if (accReg[ACCUM_W-1])
			actNext = '0;
		else if (accReg[ACCUM_W-2:FRAC_SHIFT+ACT_W-1] != '0)
			actNext = activation_t'(ACT_MAX);
		else if (rounded > ACT_MAX)
			actNext = activation_t'(ACT_MAX);
		else
			actNext = activation_t'(rounded[ACT_W-1:0]);
	end

	always_ff @(posedge clk)
	begin
		activation <= actNext;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inValid <= 1'b0;
			sumValid <= 1'b0;
			nodeValid <= 1'b0;
		end
		else
		begin
			inValid <= start;
			sumValid <= inValid;
			nodeValid <= sumValid;
		end
	end

endmodule

//--- src/inputLatch.sv
`timescale 1ns/1ps

module inputLatch
(
	input  logic clk,
	input  logic reset,
	input  logic inReq,
	output logic inAck,
	input  nnLayerPkg::inVector_t inData,
	input  logic slotFreed,
	output logic start,
	output nnLayerPkg::inVector_t vectorData
);
	import nnLayerPkg::*;

	typedef enum logic {idle, acked} latchState_t;

	latchState_t state;
	count_t credits;
	logic accept;

	// A vector is taken only if a queue slot is reserved for its result.
	assign accept = (state == idle) && inReq && (credits != '0);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			inAck <= 1'b0;
			start <= 1'b0;
		end
		else
		begin
			start <= accept;
			case (state)
				idle:
				begin
					if (accept)
					begin
						inAck <= 1'b1;
						state <= acked;
					end
				end
				acked:
				begin
					if (!inReq)
					begin
						inAck <= 1'b0;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			vectorData <= inData;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			credits <= count_t'(QUEUE_DEPTH);
		else
		begin
			case ({accept, slotFreed})
				2'b10: credits <= credits - count_t'(1);
				2'b01: credits <= credits + count_t'(1);
				default: credits <= credits;
			endcase
		end
	end

	ackHeldWhileReq: assert property (@(posedge clk) disable iff (reset)
		inAck && inReq |=> inAck);

	// Freed slots can never outnumber the vectors taken in.
	creditBound: assert property (@(posedge clk) disable iff (reset)
		credits <= QUEUE_DEPTH);

endmodule

//--- src/nnLayerPkg.sv
package nnLayerPkg;

	import nnNumericPkg::*;

	localparam int NUM_INPUTS = 10;
	localparam int NUM_NEURONS = 4;

	// The queue depth also sets the number of credits held by the input latch.
	localparam int QUEUE_DEPTH = 4;

	typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] count_t;
	typedef logic [$clog2(QUEUE_DEPTH)-1:0] queuePtr_t;

	// One row per neuron, one column per input activation.
	localparam weight_t WEIGHTS [NUM_NEURONS][NUM_INPUTS] = '{
		'{12, -20, 5, 33, -7, 18, 0, -41, 9, 26},
		'{-15, 44, -3, 8, 21, -30, 17, 6, -12, 3},
		'{0, 38, 30, 50, 52, -42, -8, 0, 0, 10},
		'{27, 0, -19, -25, 14, 36, -9, 22, 40, -6}
	};

	localparam bias_t BIASES [NUM_NEURONS] = '{
		-256,
		128,
		512,
		0
	};

	typedef struct packed {
		activation_t [NUM_INPUTS-1:0] act;
	} inVector_t;

	typedef struct packed {
		activation_t [NUM_NEURONS-1:0] act;
	} outVector_t;

endpackage

//--- src/nnNumericPkg.sv
package nnNumericPkg;

	localparam int ACT_W = 8;
	localparam int WEIGHT_W = 8;
	localparam int PRODUCT_W = ACT_W + WEIGHT_W;
	localparam int BIAS_W = 16;
	localparam int ACCUM_W = 23;

	// Low accumulator bits that fall below the output binary point.
	localparam int FRAC_SHIFT = 6;
	localparam int ACT_MAX = 127;

	typedef logic signed [ACT_W-1:0] activation_t;
	typedef logic signed [WEIGHT_W-1:0] weight_t;
	typedef logic signed [PRODUCT_W-1:0] product_t;
	typedef logic signed [BIAS_W-1:0] bias_t;

	// Ten full-scale products plus the bias fit with headroom in 23 bits.
	typedef logic signed [ACCUM_W-1:0] accum_t;

endpackage
